/* sim.sh */
#!/bin/sh
# Builds the issue stage testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -Wno-fatal --top-module issue_tb -f verilog.f -o issue_sim

./obj_dir/issue_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^sim passed$" sim.log; then
    exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1

/* verif/issue_tb.sv */
/*
 Testbench for the issue stage. Plays renamer and execute unit around
 the DUT with seeded random traffic and checks each issued op against
 a model of the scoreboard and the reservation contents.
*/
module issue_tb
    import issue_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RUN_CYCLES = 3000;
    localparam int WAIT_LIMIT = 2000;

    logic                         clk;
    logic                         rst_n;
    renamed_op_t [PUSH_WIDTH-1:0] din;
    count_t                       din_valid_ct;
    count_t                       din_ready_ct;
    logic [BCAST_LANES-1:0]       wb_valid;
    preg_t [BCAST_LANES-1:0]      wb_tag;
    renamed_op_t                  issue_op;
    logic                         issue_valid;
    logic                         issue_ready;

    integer      seed;
    int          errors;
    int          cyc;
    bit          drive_en;
    bit          gen_en;
    bit          stall_mode;  // Holds issue_ready low
    bit          timed_out;
    bit          mready [NUM_PREGS];
    bit          res_valid [NUM_PREGS];  // Resident ops keyed by their unique destination
    renamed_op_t res_op [NUM_PREGS];
    bit          res_r1 [NUM_PREGS];
    bit          res_r2 [NUM_PREGS];
    int          outstanding;
    renamed_op_t pend_q [$];
    preg_t       free_q [$];
    preg_t       recent_q [$];
    preg_t       bc_tag_q [$];
    int          bc_due_q [$];
    bit          stall_prev;
    renamed_op_t held_op;

    issue_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .din          (din),
        .din_valid_ct (din_valid_ct),
        .din_ready_ct (din_ready_ct),
        .wb_valid     (wb_valid),
        .wb_tag       (wb_tag),
        .issue_op     (issue_op),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ============================================================
    // Helpers
    // ============================================================
    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic preg_t tag_field(input renamed_op_t op, input int lsb);
        return op[lsb +: PR_ADDR_W];
    endfunction

    function automatic int cap_group(input int n);
        return (n > PUSH_WIDTH) ? PUSH_WIDTH : n;
    endfunction

    // Sources come from recent producers or from tags that are known ready
    function automatic preg_t pick_source();
        if (recent_q.size() > 0 && rand_below(2) == 0) begin
            return recent_q[rand_below(recent_q.size())];
        end
        if (free_q.size() > 0) begin
            return free_q[rand_below(free_q.size())];
        end
        return preg_t'(rand_below(NUM_PREGS));
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // ============================================================
    // Renamer and executor, driven on the falling edge
    // ============================================================
    always @(negedge clk) begin : drive
        renamed_op_t op;
        int          n;
        int          k;
        int          lane;
        if (drive_en) begin
            while (gen_en && pend_q.size() < PUSH_WIDTH && free_q.size() > 0 &&
                   rand_below(3) != 0) begin
                k = rand_below(free_q.size());
                op[DST_LSB +: PR_ADDR_W] = free_q[k];
                free_q.delete(k);
                op[OPC_LSB +: OPCODE_W]   = opcode_t'(rand_below(256));
                op[SRC1_LSB +: PR_ADDR_W] = pick_source();
                op[SRC2_LSB +: PR_ADDR_W] = pick_source();
                pend_q.push_back(op);
                recent_q.push_back(op[DST_LSB +: PR_ADDR_W]);
                if (recent_q.size() > 8) void'(recent_q.pop_front());
            end
            n = pend_q.size();
            if (n > 0 && rand_below(4) == 0) n = rand_below(n + 1);  // Offer a partial group
            din_valid_ct = count_t'(n);
            for (int i = 0; i < PUSH_WIDTH; i++) begin
                din[i] = (i < pend_q.size()) ? pend_q[i] : renamed_op_t'($random(seed));
            end
            issue_ready = stall_mode ? 1'b0 : (rand_below(4) != 0);
            wb_valid = '0;
            for (int l = 0; l < BCAST_LANES; l++) begin
                wb_tag[l] = preg_t'(rand_below(NUM_PREGS));
            end
            lane = rand_below(BCAST_LANES);
            k    = 0;
            while (k < bc_tag_q.size()) begin
                if (bc_due_q[k] <= cyc && !wb_valid[lane]) begin
                    wb_valid[lane] = 1'b1;
                    wb_tag[lane]   = bc_tag_q[k];
                    lane           = (lane + 1) % BCAST_LANES;
                    bc_tag_q.delete(k);
                    bc_due_q.delete(k);
                end else begin
                    k++;
                end
            end
        end
    end

    // ============================================================
    // Model and checks on the rising edge
    // ============================================================
    always @(posedge clk) begin : model
        bit          bcast_now [NUM_PREGS];
        int          acc;
        int          lo;
        int          hi;
        preg_t       d;
        renamed_op_t op;
        bit          r1;
        bit          r2;
        if (rst_n) begin
            cyc++;
            for (int t = 0; t < NUM_PREGS; t++) begin
                bcast_now[t] = 1'b0;
            end
            for (int l = 0; l < BCAST_LANES; l++) begin
                if (wb_valid[l]) bcast_now[wb_tag[l]] = 1'b1;
            end
            if (stall_prev) begin
                check_value("issue_valid", issue_valid, 1);
                check_value("issue_op", issue_op, held_op);
            end
            stall_prev = issue_valid && !issue_ready;
            held_op    = issue_op;
            // The skid stage holds one or two ops whenever issue_valid is high
            lo = cap_group(ELEMENTS - outstanding + (issue_valid ? 1 : 0));
            hi = cap_group(ELEMENTS - outstanding + (issue_valid ? 2 : 0));
            if (!issue_valid) begin
                check_value("din_ready_ct", din_ready_ct, lo);
            end else if (int'(din_ready_ct) < lo || int'(din_ready_ct) > hi) begin
                report_error($sformatf("din_ready_ct %0d outside %0d..%0d", din_ready_ct, lo, hi));
            end
            if (issue_valid && issue_ready) begin
                d = tag_field(issue_op, DST_LSB);
                if (!res_valid[d]) begin
                    report_error($sformatf("op %0h issued but not resident", issue_op));
                end else begin
                    check_value("issue_op", issue_op, res_op[d]);
                    if (!res_r1[d] || !res_r2[d]) begin
                        report_error($sformatf("op %0h issued before its sources", issue_op));
                    end
                    res_valid[d] = 1'b0;
                    outstanding--;
                    bc_tag_q.push_back(d);
                    bc_due_q.push_back(cyc + rand_below(6));
                end
            end
            acc = (din_valid_ct < din_ready_ct) ? din_valid_ct : din_ready_ct;
            for (int i = 0; i < acc; i++) begin
                op = din[i];
                r1 = mready[tag_field(op, SRC1_LSB)] || bcast_now[tag_field(op, SRC1_LSB)];
                r2 = mready[tag_field(op, SRC2_LSB)] || bcast_now[tag_field(op, SRC2_LSB)];
                for (int j = 0; j < i; j++) begin
                    if (tag_field(din[j], DST_LSB) == tag_field(op, SRC1_LSB)) r1 = 1'b0;
                    if (tag_field(din[j], DST_LSB) == tag_field(op, SRC2_LSB)) r2 = 1'b0;
                end
                d            = tag_field(op, DST_LSB);
                res_valid[d] = 1'b1;
                res_op[d]    = op;
                res_r1[d]    = r1;
                res_r2[d]    = r2;
                outstanding++;
                void'(pend_q.pop_front());
            end
            for (int t = 0; t < NUM_PREGS; t++) begin
                if (bcast_now[t]) begin
                    mready[t] = 1'b1;
                    free_q.push_back(preg_t'(t));
                    for (int e = 0; e < NUM_PREGS; e++) begin
                        if (res_valid[e] && tag_field(res_op[e], SRC1_LSB) == t) res_r1[e] = 1'b1;
                        if (res_valid[e] && tag_field(res_op[e], SRC2_LSB) == t) res_r2[e] = 1'b1;
                    end
                end
            end
            for (int i = 0; i < acc; i++) begin
                mready[tag_field(din[i], DST_LSB)] = 1'b0;  // New producer wins over broadcast
            end
        end
    end

    // ============================================================
    // Sequence
    // ============================================================
    task automatic wait_full();
        int n;
        n = 0;
        while (din_ready_ct != 0 && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (din_ready_ct != 0) begin
            timed_out = 1'b1;
            report_error("timeout, din_ready_ct never reached zero during the stall");
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while ((pend_q.size() != 0 || outstanding != 0 || bc_tag_q.size() != 0) &&
               n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (pend_q.size() != 0 || outstanding != 0 || bc_tag_q.size() != 0) begin
            timed_out = 1'b1;
            report_error($sformatf("timeout, %0d ops still resident after drain", outstanding));
        end
    endtask

    task automatic finish_run();
        $display("Run finished after %0d cycles with %0d errors", cyc, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    initial begin
        seed         = 32'hcaaa_4d59;
        errors       = 0;
        cyc          = 0;
        drive_en     = 1'b0;
        gen_en       = 1'b0;
        stall_mode   = 1'b0;
        timed_out    = 1'b0;
        outstanding  = 0;
        stall_prev   = 1'b0;
        held_op      = '0;
        rst_n        = 1'b0;
        din          = '0;
        din_valid_ct = '0;
        wb_valid     = '0;
        wb_tag       = '0;
        issue_ready  = 1'b0;
        for (int t = 0; t < NUM_PREGS; t++) begin
            mready[t]    = 1'b1;
            res_valid[t] = 1'b0;
            free_q.push_back(preg_t'(t));
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        step();
        check_value("issue_valid", issue_valid, 0);
        check_value("din_ready_ct", din_ready_ct, PUSH_WIDTH);
        drive_en = 1'b1;
        gen_en   = 1'b1;
        repeat (RUN_CYCLES) step();
        stall_mode = 1'b1;
        wait_full();
        repeat (20) step();
        gen_en     = 1'b0;
        stall_mode = 1'b0;
        if (!timed_out) wait_drained();
        if (!timed_out) begin
            check_value("issue_valid", issue_valid, 0);
            check_value("din_ready_ct", din_ready_ct, PUSH_WIDTH);
        end
        finish_run();
    end

endmodule

/* verilog.f */
verilog/issue_pkg.sv
verilog/prf_scoreboard.sv
verilog/dispatch_stage.sv
verilog/issue_entry.sv
verilog/issue_buffer_ooo.sv
verilog/issue_output_stage.sv
verilog/issue_top.sv
verif/issue_tb.sv

/* verilog/dispatch_stage.sv */
/*
 Combinational dispatch. Limits acceptance to the free entry count,
 tags each accepted op with source ready bits and marks the
 destinations busy in the scoreboard.
*/
module dispatch_stage
    import issue_pkg::*;
(
    input  renamed_op_t [PUSH_WIDTH-1:0] din,
    input  count_t                       din_valid_ct,
    input  count_t                       free_ct,
    input  logic [NUM_PREGS-1:0]         preg_ready,
    input  logic [BCAST_LANES-1:0]       wb_valid,
    input  preg_t [BCAST_LANES-1:0]      wb_tag,
    output count_t                       din_ready_ct,
    output count_t                       accept_ct,
    output issue_op_t [PUSH_WIDTH-1:0]   annot_ops,
    output logic [PUSH_WIDTH-1:0]        busy_valid,
    output preg_t [PUSH_WIDTH-1:0]       busy_tag
);

    // ============================================================
    // Acceptance count
    // ============================================================
    always_comb begin
        din_ready_ct = (free_ct > count_t'(PUSH_WIDTH)) ? count_t'(PUSH_WIDTH) : free_ct;
        accept_ct    = (din_valid_ct < din_ready_ct) ? din_valid_ct : din_ready_ct;
    end

    // ============================================================
    // Source readiness with broadcast bypass and in-group hazards
    // ============================================================
    always_comb begin
        preg_t src1;
        preg_t src2;
        logic  rdy1;
        logic  rdy2;
        for (int i = 0; i < PUSH_WIDTH; i++) begin
            src1 = din[i][SRC1_LSB +: PR_ADDR_W];
            src2 = din[i][SRC2_LSB +: PR_ADDR_W];
            rdy1 = preg_ready[src1] | wb_hit(wb_valid, wb_tag, src1);
            rdy2 = preg_ready[src2] | wb_hit(wb_valid, wb_tag, src2);
            for (int j = 0; j < i; j++) begin
                // An older op in this group produces the tag, so wait for its broadcast
                if (count_t'(j) < accept_ct) begin
                    if (din[j][DST_LSB +: PR_ADDR_W] == src1) rdy1 = 1'b0;
                    if (din[j][DST_LSB +: PR_ADDR_W] == src2) rdy2 = 1'b0;
                end
            end
            annot_ops[i] = {din[i], rdy1, rdy2};
        end
    end

    always_comb begin
        for (int i = 0; i < PUSH_WIDTH; i++) begin
            busy_valid[i] = (count_t'(i) < accept_ct);
            busy_tag[i]   = din[i][DST_LSB +: PR_ADDR_W];
        end
    end

endmodule

/* verilog/issue_buffer_ooo.sv */
/*
 Out-of-order issue buffer. Takes up to four annotated ops a cycle
 into free entries and hands the lowest-index ready entry to the
 output stage, one op per cycle.
*/
module issue_buffer_ooo
    import issue_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  issue_op_t [PUSH_WIDTH-1:0] annot_ops,
    input  count_t                     accept_ct,
    input  logic [BCAST_LANES-1:0]     wb_valid,
    input  preg_t [BCAST_LANES-1:0]    wb_tag,
    input  logic                       sel_ready,
    output count_t                     free_ct,
    output renamed_op_t                sel_op,
    output logic                       sel_valid
);

    logic [ELEMENTS-1:0]    occupied;
    logic [ELEMENTS-1:0]    req;
    logic [ELEMENTS-1:0]    wr_en;
    logic [ELEMENTS-1:0]    release_en;
    issue_op_t              wr_op [ELEMENTS];
    renamed_op_t            entry_op [ELEMENTS];
    logic [ENTRY_IDX_W-1:0] sel_idx;

    for (genvar g = 0; g < ELEMENTS; g++) begin : g_entry
        issue_entry u_entry (
            .clk        (clk),
            .rst_n      (rst_n),
            .wr_en      (wr_en[g]),
            .wr_op      (wr_op[g]),
            .release_en (release_en[g]),
            .wb_valid   (wb_valid),
            .wb_tag     (wb_tag),
            .occupied   (occupied[g]),
            .req        (req[g]),
            .entry_op   (entry_op[g])
        );
    end

    // ============================================================
    // Free count and allocation
    // ============================================================
    always_comb begin
        count_t cnt;
        cnt = '0;
        for (int e = 0; e < ELEMENTS; e++) begin
            if (!occupied[e] && cnt < count_t'(PUSH_WIDTH)) cnt = cnt + 1'b1;  // Saturates at group size
        end
        free_ct = cnt;
    end

    always_comb begin
        count_t slot;
        slot  = '0;
        wr_en = '0;
        for (int e = 0; e < ELEMENTS; e++) begin
            wr_op[e] = annot_ops[0];
            if (!occupied[e] && slot < accept_ct) begin
                wr_op[e] = annot_ops[slot[SLOT_IDX_W-1:0]];
                wr_en[e] = 1'b1;
                slot     = slot + 1'b1;
            end
        end
    end

    // ============================================================
    // Selection
    // ============================================================
    always_comb begin
        sel_valid = 1'b0;
        sel_idx   = '0;
        for (int e = ELEMENTS - 1; e >= 0; e--) begin
            if (req[e]) begin
                sel_valid = 1'b1;
                sel_idx   = ENTRY_IDX_W'(e);  // Last hit in the downward scan is the lowest index
            end
        end
    end

    assign sel_op = entry_op[sel_idx];

    always_comb begin
        for (int e = 0; e < ELEMENTS; e++) begin
            release_en[e] = sel_valid && sel_ready && (sel_idx == ENTRY_IDX_W'(e));
        end
    end

endmodule

/* verilog/issue_entry.sv */
/*
 One reservation entry. Holds an op, watches the writeback lanes
 for its two sources and requests issue once both are ready.
*/
module issue_entry
    import issue_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  issue_op_t               wr_op,
    input  logic                    release_en,
    input  logic [BCAST_LANES-1:0]  wb_valid,
    input  preg_t [BCAST_LANES-1:0] wb_tag,
    output logic                    occupied,
    output logic                    req,
    output renamed_op_t             entry_op
);

    logic        occupied_q;
    logic        rdy1_q;
    logic        rdy2_q;
    renamed_op_t op_q;
    preg_t       src1;
    preg_t       src2;

    assign src1 = op_q[SRC1_LSB +: PR_ADDR_W];
    assign src2 = op_q[SRC2_LSB +: PR_ADDR_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupied_q <= 1'b0;
            rdy1_q     <= 1'b0;
            rdy2_q     <= 1'b0;
        end else if (wr_en) begin
            occupied_q <= 1'b1;
            rdy1_q     <= wr_op[RDY1_BIT];  // Same-cycle broadcasts were folded in by dispatch
            rdy2_q     <= wr_op[RDY2_BIT];
        end else begin
            if (release_en) occupied_q <= 1'b0;
            if (wb_hit(wb_valid, wb_tag, src1)) rdy1_q <= 1'b1;
            if (wb_hit(wb_valid, wb_tag, src2)) rdy2_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) op_q <= wr_op[OP_LSB +: RENAMED_OP_W];
    end

    assign occupied = occupied_q;
    assign req      = occupied_q & rdy1_q & rdy2_q;
    assign entry_op = op_q;

endmodule

/* verilog/issue_output_stage.sv */
/*
 Two-entry skid buffer in front of the execute port.
 The head op is held stable until the execute side takes it.
*/
module issue_output_stage
    import issue_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  renamed_op_t sel_op,
    input  logic        sel_valid,
    output logic        sel_ready,
    output renamed_op_t issue_op,
    output logic        issue_valid,
    input  logic        issue_ready
);

    out_state_t  state_q;
    renamed_op_t head_q;
    renamed_op_t tail_q;
    logic        push;
    logic        pop;

    assign sel_ready   = (state_q != TWO);
    assign issue_valid = (state_q != EMPTY);
    assign push        = sel_valid & sel_ready;
    assign pop         = issue_valid & issue_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= EMPTY;
        end else begin
            case (state_q)
                EMPTY: if (push) state_q <= ONE;
                ONE: begin
                    if (push && !pop) state_q <= TWO;
                    else if (!push && pop) state_q <= EMPTY;
                end
                TWO: if (pop) state_q <= ONE;  // Full, so nothing is pushed here
                default: state_q <= EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            EMPTY: if (push) head_q <= sel_op;
            ONE: begin
                if (push && pop) head_q <= sel_op;
                else if (push) tail_q <= sel_op;
            end
            TWO: if (pop) head_q <= tail_q;
            default: head_q <= head_q;
        endcase
    end

    assign issue_op = head_q;

endmodule

/* verilog/issue_pkg.sv */
/*
 Shared widths, op formats and helpers for the issue stage.
 Modules pull these in with a wildcard import in their header.
*/
package issue_pkg;

    // ============================================================
    // Sizes
    // ============================================================
    localparam int PR_ADDR_W   = 6;
    localparam int NUM_PREGS   = 64;
    localparam int PUSH_WIDTH  = 4;
    localparam int SLOT_IDX_W  = 2;  // Index of a slot in a dispatch group
    localparam int CT_W        = 3;
    localparam int ELEMENTS    = 8;
    localparam int ENTRY_IDX_W = 3;
    localparam int BCAST_LANES = 6;
    localparam int OPCODE_W    = 8;

    // ============================================================
    // Op layout {opcode, dst, src1, src2} and {op, src1_rdy, src2_rdy}
    // ============================================================
    localparam int RENAMED_OP_W = OPCODE_W + 3 * PR_ADDR_W;
    localparam int ISSUE_OP_W   = RENAMED_OP_W + 2;
    localparam int SRC2_LSB     = 0;
    localparam int SRC1_LSB     = PR_ADDR_W;
    localparam int DST_LSB      = 2 * PR_ADDR_W;
    localparam int OPC_LSB      = 3 * PR_ADDR_W;
    localparam int RDY2_BIT     = 0;
    localparam int RDY1_BIT     = 1;
    localparam int OP_LSB       = 2;  // Renamed op sits above the two ready bits

    typedef logic [PR_ADDR_W-1:0]    preg_t;
    typedef logic [OPCODE_W-1:0]     opcode_t;
    typedef logic [RENAMED_OP_W-1:0] renamed_op_t;
    typedef logic [ISSUE_OP_W-1:0]   issue_op_t;
    typedef logic [CT_W-1:0]         count_t;

    typedef enum logic [1:0] {EMPTY, ONE, TWO} out_state_t;

    // True when any valid writeback lane carries the given tag
    function automatic logic wb_hit(input logic [BCAST_LANES-1:0] valid,
                                    input preg_t [BCAST_LANES-1:0] tags,
                                    input preg_t tag);
        logic hit;
        hit = 1'b0;
        for (int l = 0; l < BCAST_LANES; l++) begin
            if (valid[l] && tags[l] == tag) hit = 1'b1;
        end
        return hit;
    endfunction

endpackage

/* verilog/issue_top.sv */
/*
 Issue stage top level. Scoreboard and dispatch feed the
 reservation buffer, which drains through the skid stage.
*/
module issue_top
    import issue_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  renamed_op_t [PUSH_WIDTH-1:0] din,
    input  count_t                       din_valid_ct,
    output count_t                       din_ready_ct,
    input  logic [BCAST_LANES-1:0]       wb_valid,
    input  preg_t [BCAST_LANES-1:0]      wb_tag,
    output renamed_op_t                  issue_op,
    output logic                         issue_valid,
    input  logic                         issue_ready
);

    logic [NUM_PREGS-1:0]       preg_ready;
    logic [PUSH_WIDTH-1:0]      busy_valid;
    preg_t [PUSH_WIDTH-1:0]     busy_tag;
    issue_op_t [PUSH_WIDTH-1:0] annot_ops;
    count_t                     accept_ct;
    count_t                     free_ct;
    renamed_op_t                sel_op;
    logic                       sel_valid;
    logic                       sel_ready;

    prf_scoreboard u_scoreboard (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_valid   (wb_valid),
        .wb_tag     (wb_tag),
        .busy_valid (busy_valid),
        .busy_tag   (busy_tag),
        .preg_ready (preg_ready)
    );

    dispatch_stage u_dispatch (
        .din          (din),
        .din_valid_ct (din_valid_ct),
        .free_ct      (free_ct),
        .preg_ready   (preg_ready),
        .wb_valid     (wb_valid),
        .wb_tag       (wb_tag),
        .din_ready_ct (din_ready_ct),
        .accept_ct    (accept_ct),
        .annot_ops    (annot_ops),
        .busy_valid   (busy_valid),
        .busy_tag     (busy_tag)
    );

    issue_buffer_ooo u_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .annot_ops (annot_ops),
        .accept_ct (accept_ct),
        .wb_valid  (wb_valid),
        .wb_tag    (wb_tag),
        .sel_ready (sel_ready),
        .free_ct   (free_ct),
        .sel_op    (sel_op),
        .sel_valid (sel_valid)
    );

    issue_output_stage u_output (
        .clk         (clk),
        .rst_n       (rst_n),
        .sel_op      (sel_op),
        .sel_valid   (sel_valid),
        .sel_ready   (sel_ready),
        .issue_op    (issue_op),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready)
    );

endmodule

/* verilog/prf_scoreboard.sv */
/*
 Physical register scoreboard, one ready bit per tag.
 Writeback broadcasts set a bit, accepted destinations clear it.
 Updates land on the next clock edge.
*/
module prf_scoreboard
    import issue_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [BCAST_LANES-1:0]       wb_valid,
    input  preg_t [BCAST_LANES-1:0]      wb_tag,
    input  logic [PUSH_WIDTH-1:0]        busy_valid,
    input  preg_t [PUSH_WIDTH-1:0]       busy_tag,
    output logic [NUM_PREGS-1:0]         preg_ready
);

    logic [NUM_PREGS-1:0] ready_q;
    logic [NUM_PREGS-1:0] ready_d;

    always_comb begin
        ready_d = ready_q;
        for (int l = 0; l < BCAST_LANES; l++) begin
            if (wb_valid[l]) ready_d[wb_tag[l]] = 1'b1;
        end
        // A new producer is younger than any broadcast on the same tag
        for (int s = 0; s < PUSH_WIDTH; s++) begin
            if (busy_valid[s]) ready_d[busy_tag[s]] = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_q <= '1;  // Every register holds an architectural value after reset
        end else begin
            ready_q <= ready_d;
        end
    end

    assign preg_ready = ready_q;

endmodule
